//--- design/control_driver.sv
`timescale 1ns/10ps

module control_driver import mcu_ctrl_pkg::*; (
    input  state_t   state,
    input  decoded_t held,
    output logic     pc_mux_ena,
    output logic     pc_write,
    output logic     im_read,
    output logic     zero_write,
    output logic     alu_ena,
    output logic     reg_write,
    output alu_op_t  alu_op,
    output a_sel_t   a_sel,
    output b_sel_t   b_sel,
    output ext_sel_t ext_sel,
    output pc_sel_t  pc_sel,
    output wd_sel_t  wd_sel,
    output wa_sel_t  wa_sel,
    output load_t    load_type,
    output store_t   store_size,
    output logic     jump_concat
);

    always_comb begin
        pc_mux_ena  = 1'b0;
        pc_write    = 1'b0;
        im_read     = 1'b0;
        zero_write  = 1'b0;
        alu_ena     = 1'b0;
        reg_write   = 1'b0;
        alu_op      = ALU_ADDU;
        a_sel       = A_PC;
        b_sel       = B_FOUR;
        ext_sel     = EXT_NONE;
        pc_sel      = PC_ALU;
        wd_sel      = WD_NONE;
        wa_sel      = WA_NONE;
        load_type   = LD_NONE;
        store_size  = ST_NONE;
        jump_concat = 1'b0;

        case (state)
            S_IF: begin
                // Fetch and PC + 4 through the ALU
                im_read    = 1'b1;
                pc_mux_ena = 1'b1;
                alu_ena    = 1'b1;
                zero_write = 1'b1;
            end

            S_ID: begin
                pc_mux_ena = 1'b1;
                pc_write   = 1'b1;
                if (held.cls == CLS_JUMP) begin
                    pc_sel      = held.absolute ? PC_JUMP : PC_REG;
                    jump_concat = held.absolute;
                    if (held.links) begin
                        reg_write = 1'b1;
                        wd_sel    = WD_PC;
                        wa_sel    = held.link_wa;
                    end
                end
            end

            S_EXE_J: begin
                pc_mux_ena  = 1'b1;
                pc_write    = 1'b1;
                pc_sel      = held.absolute ? PC_JUMP : PC_REG;
                jump_concat = held.absolute;
            end

            S_EXE_B: begin
                zero_write = 1'b1;
                alu_ena    = 1'b1;
                alu_op     = held.alu_op;
                a_sel      = held.a_sel;
                b_sel      = held.b_sel;
            end

            S_EXE_B1: begin
                // PC plus shifted offset
                pc_mux_ena = 1'b1;
                pc_write   = 1'b1;
                zero_write = 1'b1;
                alu_ena    = 1'b1;
                alu_op     = ALU_ADD;
                a_sel      = A_PC;
                b_sel      = B_IMM;
                ext_sel    = held.ext_sel;
            end

            S_EXE_LS, S_EXE_ALU: begin
                zero_write = 1'b1;
                alu_ena    = 1'b1;
                alu_op     = held.alu_op;
                a_sel      = held.a_sel;
                b_sel      = held.b_sel;
                ext_sel    = held.ext_sel;
            end

            S_EXE_LS1: begin
                load_type  = held.load_kind;
                store_size = held.store_kind;
                if (held.is_load) begin
                    reg_write = 1'b1;
                    wd_sel    = WD_MEM;
                    wa_sel    = WA_RT;
                end
            end

            S_WB: begin
                reg_write = 1'b1;
                wd_sel    = WD_ALU;
                wa_sel    = held.wb_wa;
            end

            default: ;
        endcase
    end

endmodule

//--- design/decode_latch.sv
`timescale 1ns/10ps

module decode_latch import mcu_ctrl_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  state_t   state,
    input  decoded_t dec,
    output decoded_t held
);

    // Capture at the end of fetch, hold through execute
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            held <= DEC_NOP;
        end else if (state == S_IF) begin
            held <= dec;
        end
    end

endmodule

//--- design/insn_decoder.sv
`timescale 1ns/10ps

module insn_decoder import mcu_ctrl_pkg::*; (
    input  logic [31:0] inst,
    output decoded_t    dec
);

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [4:0] rt;

    assign opcode = inst[31:26];
    assign funct  = inst[5:0];
    assign rt     = inst[20:16];

    always_comb begin
        dec = DEC_NOP;
        case (opcode)
            OP_SPECIAL: begin
                if (inst != 32'd0) begin
                    dec.cls   = CLS_ALU;
                    dec.a_sel = A_RS;
                    dec.b_sel = B_RT;
                    dec.wb_wa = WA_RD;
                    case (funct)
                        FN_ADD:          dec.alu_op = ALU_ADD;
                        FN_ADDU:         dec.alu_op = ALU_ADDU;
                        FN_SUB:          dec.alu_op = ALU_SUB;
                        FN_SUBU:         dec.alu_op = ALU_SUBU;
                        FN_AND:          dec.alu_op = ALU_AND;
                        FN_OR:           dec.alu_op = ALU_OR;
                        FN_XOR:          dec.alu_op = ALU_XOR;
                        FN_NOR:          dec.alu_op = ALU_NOR;
                        FN_SLT:          dec.alu_op = ALU_SLT;
                        FN_SLTU:         dec.alu_op = ALU_SLTU;
                        FN_SLL, FN_SLLV: dec.alu_op = ALU_SLL;
                        FN_SRL, FN_SRLV: dec.alu_op = ALU_SRL;
                        FN_SRA, FN_SRAV: dec.alu_op = ALU_SRA;
                        FN_JR, FN_JALR: begin
                            dec            = DEC_NOP;
                            dec.cls        = CLS_JUMP;
                            dec.reg_target = 1'b1;
                            dec.links      = (funct == FN_JALR);
                            // JALR with rt zero links through $ra
                            dec.link_wa    = (rt == 5'd0) ? WA_RA : WA_RD;
                        end
                        default: dec = DEC_NOP;
                    endcase
                    // Shift amount from the instruction or from rs
                    if (funct inside {FN_SLL, FN_SRL, FN_SRA}) begin
                        dec.a_sel   = A_SHAMT_IMM;
                        dec.ext_sel = EXT_SHAMT;
                    end else if (funct inside {FN_SLLV, FN_SRLV, FN_SRAV}) begin
                        dec.a_sel = A_SHAMT_RS;
                    end
                end
            end

            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                dec.cls     = CLS_ALU;
                dec.a_sel   = A_RS;
                dec.b_sel   = B_IMM;
                dec.wb_wa   = WA_RT;
                dec.ext_sel = (opcode inside {OP_ADDI, OP_ADDIU, OP_SLTI}) ? EXT_SIGN
                                                                          : EXT_ZERO;
                case (opcode)
                    OP_ADDI:  dec.alu_op = ALU_ADD;
                    OP_ADDIU: dec.alu_op = ALU_ADDU;
                    OP_SLTI:  dec.alu_op = ALU_SLT;
                    OP_SLTIU: dec.alu_op = ALU_SLTU;
                    OP_ANDI:  dec.alu_op = ALU_AND;
                    OP_ORI:   dec.alu_op = ALU_OR;
                    OP_XORI:  dec.alu_op = ALU_XOR;
                    default:  dec.alu_op = ALU_LUI;
                endcase
            end

            OP_BEQ, OP_BNE, OP_BGEZ: begin
                dec.cls     = CLS_BRANCH;
                dec.alu_op  = ALU_SUB;   // compare by subtraction
                dec.a_sel   = A_RS;
                dec.b_sel   = (opcode == OP_BGEZ) ? B_ZERO : B_RT;
                dec.ext_sel = EXT_BRANCH;
                dec.br_kind = (opcode == OP_BEQ) ? BR_EQ :
                              (opcode == OP_BNE) ? BR_NE : BR_GEZ;
            end

            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_SB, OP_SH, OP_SW: begin
                dec.cls     = CLS_MEM;
                dec.alu_op  = ALU_ADD;   // base plus offset
                dec.a_sel   = A_RS;
                dec.b_sel   = B_IMM;
                dec.ext_sel = EXT_SIGN;
                dec.is_load = ~opcode[3];
                case (opcode)
                    OP_LB:   dec.load_kind  = LD_BYTE;
                    OP_LBU:  dec.load_kind  = LD_BYTE_U;
                    OP_LH:   dec.load_kind  = LD_HALF;
                    OP_LHU:  dec.load_kind  = LD_HALF_U;
                    OP_LW:   dec.load_kind  = LD_WORD;
                    OP_SB:   dec.store_kind = ST_BYTE;
                    OP_SH:   dec.store_kind = ST_HALF;
                    default: dec.store_kind = ST_WORD;
                endcase
            end

            OP_J, OP_JAL: begin
                dec.cls      = CLS_JUMP;
                dec.absolute = 1'b1;
                dec.links    = (opcode == OP_JAL);
                dec.link_wa  = WA_RA;
            end

            default: dec = DEC_NOP;
        endcase
    end

endmodule

//--- design/mcu_control.sv
`timescale 1ns/10ps

module mcu_control import mcu_ctrl_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] inst,
    input  logic        alu_zero,
    input  logic        alu_nega,
    output logic        pc_mux_ena,
    output logic        pc_write,
    output logic        im_read,
    output logic        zero_write,
    output logic        alu_ena,
    output logic        reg_write,
    output alu_op_t     alu_op,
    output a_sel_t      a_sel,
    output b_sel_t      b_sel,
    output ext_sel_t    ext_sel,
    output pc_sel_t     pc_sel,
    output wd_sel_t     wd_sel,
    output wa_sel_t     wa_sel,
    output load_t       load_type,
    output store_t      store_size,
    output logic        jump_concat,
    output logic        finish
);

    decoded_t dec;
    decoded_t held;
    state_t   state;

    insn_decoder i_decoder (
        .inst (inst),
        .dec  (dec)
    );

    decode_latch i_latch (
        .clk   (clk),
        .reset (reset),
        .state (state),
        .dec   (dec),
        .held  (held)
    );

    state_sequencer i_sequencer (
        .clk      (clk),
        .reset    (reset),
        .held     (held),
        .alu_zero (alu_zero),
        .alu_nega (alu_nega),
        .state    (state),
        .finish   (finish)
    );

    control_driver i_driver (
        .state       (state),
        .held        (held),
        .pc_mux_ena  (pc_mux_ena),
        .pc_write    (pc_write),
        .im_read     (im_read),
        .zero_write  (zero_write),
        .alu_ena     (alu_ena),
        .reg_write   (reg_write),
        .alu_op      (alu_op),
        .a_sel       (a_sel),
        .b_sel       (b_sel),
        .ext_sel     (ext_sel),
        .pc_sel      (pc_sel),
        .wd_sel      (wd_sel),
        .wa_sel      (wa_sel),
        .load_type   (load_type),
        .store_size  (store_size),
        .jump_concat (jump_concat)
    );

endmodule

//--- design/mcu_ctrl_pkg.sv
package mcu_ctrl_pkg;

    //////////////////////////////
    // Machine states
    typedef enum logic [3:0] {
        S_IF      = 4'b0000,
        S_ID      = 4'b0001,
        S_EXE_J   = 4'b0010,
        S_EXE_ALU = 4'b0011,
        S_EXE_B   = 4'b0100,
        S_EXE_B1  = 4'b0101, // taken branch, PC update
        S_EXE_LS  = 4'b0110,
        S_EXE_LS1 = 4'b0111, // memory access
        S_WB      = 4'b1000
    } state_t;

    typedef enum logic [2:0] {
        CLS_NOP,
        CLS_ALU,
        CLS_BRANCH,
        CLS_MEM,
        CLS_JUMP
    } insn_class_t;

    typedef enum logic [3:0] {
        ALU_ADDU = 4'b0000,
        ALU_SUBU = 4'b0001,
        ALU_ADD  = 4'b0010,
        ALU_SUB  = 4'b0011,
        ALU_AND  = 4'b0100,
        ALU_OR   = 4'b0101,
        ALU_XOR  = 4'b0110,
        ALU_NOR  = 4'b0111,
        ALU_LUI  = 4'b1000,
        ALU_SLTU = 4'b1010,
        ALU_SLT  = 4'b1011,
        ALU_SRA  = 4'b1100,
        ALU_SRL  = 4'b1101,
        ALU_SLL  = 4'b1110
    } alu_op_t;

    //////////////////////////////
    // Datapath mux selects
    typedef enum logic [1:0] {A_PC, A_RS, A_SHAMT_RS, A_SHAMT_IMM} a_sel_t;
    typedef enum logic [1:0] {B_FOUR, B_RT, B_IMM, B_ZERO} b_sel_t;

    // None shares the sign code, only read where it matters
    typedef logic [1:0] ext_sel_t;
    localparam ext_sel_t EXT_SIGN   = 2'b00;
    localparam ext_sel_t EXT_ZERO   = 2'b01;
    localparam ext_sel_t EXT_SHAMT  = 2'b10;
    localparam ext_sel_t EXT_BRANCH = 2'b11;
    localparam ext_sel_t EXT_NONE   = 2'b00;

    typedef enum logic [1:0] {PC_ALU = 2'b00, PC_JUMP = 2'b01, PC_REG = 2'b10} pc_sel_t;

    typedef enum logic [2:0] {
        WD_PC   = 3'b000,
        WD_ALU  = 3'b001,
        WD_MEM  = 3'b010,
        WD_NONE = 3'b111
    } wd_sel_t;

    typedef enum logic [1:0] {WA_RD, WA_RT, WA_RA, WA_NONE} wa_sel_t;

    typedef enum logic [2:0] {
        LD_WORD   = 3'b000,
        LD_BYTE   = 3'b001,
        LD_BYTE_U = 3'b010,
        LD_HALF   = 3'b011,
        LD_HALF_U = 3'b100,
        LD_NONE   = 3'b111
    } load_t;

    typedef enum logic [1:0] {ST_NONE, ST_WORD, ST_HALF, ST_BYTE} store_t;
    typedef enum logic [1:0] {BR_EQ, BR_NE, BR_GEZ} br_kind_t;

    typedef struct packed {
        insn_class_t cls;
        alu_op_t     alu_op;
        a_sel_t      a_sel;
        b_sel_t      b_sel;
        ext_sel_t    ext_sel;
        br_kind_t    br_kind;
        logic        is_load;
        load_t       load_kind;
        store_t      store_kind;
        logic        links;      // JAL, JALR
        logic        reg_target; // JR, JALR
        logic        absolute;   // J, JAL
        wa_sel_t     link_wa;
        wa_sel_t     wb_wa;
    } decoded_t;

    localparam decoded_t DEC_NOP = '{
        cls: CLS_NOP, alu_op: ALU_ADDU, a_sel: A_PC, b_sel: B_FOUR,
        ext_sel: EXT_NONE, br_kind: BR_EQ, is_load: 1'b0,
        load_kind: LD_NONE, store_kind: ST_NONE, links: 1'b0,
        reg_target: 1'b0, absolute: 1'b0, link_wa: WA_NONE, wb_wa: WA_NONE
    };

    //////////////////////////////
    // Opcode and function fields
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_ADDI  = 6'b001000;
    localparam logic [5:0] OP_ADDIU = 6'b001001;
    localparam logic [5:0] OP_SLTI  = 6'b001010;
    localparam logic [5:0] OP_SLTIU = 6'b001011;
    localparam logic [5:0] OP_ANDI  = 6'b001100;
    localparam logic [5:0] OP_ORI   = 6'b001101;
    localparam logic [5:0] OP_XORI  = 6'b001110;
    localparam logic [5:0] OP_LUI   = 6'b001111;
    localparam logic [5:0] OP_J     = 6'b000010;
    localparam logic [5:0] OP_JAL   = 6'b000011;
    localparam logic [5:0] OP_LB    = 6'b100000;
    localparam logic [5:0] OP_LH    = 6'b100001;
    localparam logic [5:0] OP_LW    = 6'b100011;
    localparam logic [5:0] OP_LBU   = 6'b100100;
    localparam logic [5:0] OP_LHU   = 6'b100101;
    localparam logic [5:0] OP_SB    = 6'b101000;
    localparam logic [5:0] OP_SH    = 6'b101001;
    localparam logic [5:0] OP_SW    = 6'b101011;
    localparam logic [5:0] OP_BEQ   = 6'b000100;
    localparam logic [5:0] OP_BNE   = 6'b000101;
    localparam logic [5:0] OP_BGEZ  = 6'b000001; // REGIMM group

    localparam logic [5:0] FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;
    localparam logic [5:0] FN_JR   = 6'b001000;
    localparam logic [5:0] FN_JALR = 6'b001001;
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_SLLV = 6'b000100;
    localparam logic [5:0] FN_SRLV = 6'b000110;
    localparam logic [5:0] FN_SRAV = 6'b000111;

endpackage

//--- design/state_sequencer.sv
`timescale 1ns/10ps

module state_sequencer import mcu_ctrl_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  decoded_t held,
    input  logic     alu_zero,
    input  logic     alu_nega,
    output state_t   state,
    output logic     finish
);

    state_t next_state;
    logic   taken;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= S_IF;
        end else begin
            state <= next_state;
        end
    end

    // Branch condition from the flags of the compare
    always_comb begin
        case (held.br_kind)
            BR_EQ:   taken = alu_zero;
            BR_NE:   taken = ~alu_zero;
            default: taken = ~alu_nega;
        endcase
    end

    //////////////////////////////
    // Next state
    always_comb begin
        next_state = S_IF;
        case (state)
            S_IF: next_state = S_ID;
            S_ID: begin
                case (held.cls)
                    CLS_JUMP:   next_state = held.links ? S_EXE_J : S_IF;
                    CLS_BRANCH: next_state = S_EXE_B;
                    CLS_MEM:    next_state = S_EXE_LS;
                    CLS_ALU:    next_state = S_EXE_ALU;
                    default:    next_state = S_IF; // no-op
                endcase
            end
            S_EXE_B:   next_state = taken ? S_EXE_B1 : S_IF;
            S_EXE_LS:  next_state = S_EXE_LS1;
            S_EXE_ALU: next_state = S_WB;
            default:   next_state = S_IF;
        endcase
    end

    assign finish = (next_state == S_IF); // last cycle of the instruction

endmodule

//--- mcu_control.f
design/mcu_ctrl_pkg.sv
design/insn_decoder.sv
design/decode_latch.sv
design/state_sequencer.sv
design/control_driver.sv
design/mcu_control.sv
tb/mcu_checker.sv
tb/tb_mcu_control.sv

//--- tb/mcu_checker.sv
`timescale 1ns/10ps

module mcu_checker import mcu_ctrl_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] inst,
    input  logic        alu_zero,
    input  logic        alu_nega,
    input  logic        pc_mux_ena,
    input  logic        pc_write,
    input  logic        im_read,
    input  logic        zero_write,
    input  logic        alu_ena,
    input  logic        reg_write,
    input  alu_op_t     alu_op,
    input  a_sel_t      a_sel,
    input  b_sel_t      b_sel,
    input  ext_sel_t    ext_sel,
    input  pc_sel_t     pc_sel,
    input  wd_sel_t     wd_sel,
    input  wa_sel_t     wa_sel,
    input  load_t       load_type,
    input  store_t      store_size,
    input  logic        jump_concat,
    input  logic        finish,
    output int          error_count,
    output int          check_count
);

    typedef enum logic [2:0] {G_NOP, G_ALU, G_BRANCH, G_MEM, G_JUMP} group_t;

    typedef struct packed {
        group_t     group;
        logic [2:0] cycles;
        alu_op_t    alu_op;
        a_sel_t     a_sel;
        b_sel_t     b_sel;
        ext_sel_t   ext_sel;
        wa_sel_t    wa;       // writeback or link target
        load_t      ld;
        store_t     st;
        logic       taken;
        logic       links;
        logic       absolute;
    } expect_t;

    expect_t cur;
    int      idx;
    logic    first;
    string   tname;

    initial begin
        error_count = 0;
        check_count = 0;
    end

    //////////////////////////////
    // Expected behavior per instruction
    function automatic expect_t reference(input logic [31:0] ins, input logic zero,
                                          input logic nega);
        expect_t    e;
        logic [5:0] op;
        logic [5:0] fn;
        op = ins[31:26];
        fn = ins[5:0];
        e = '0;
        e.group = G_NOP;
        e.a_sel = A_RS;
        e.ld    = LD_NONE;
        e.st    = ST_NONE;
        case (op)
            6'h00: begin
                e.group   = G_ALU;
                e.b_sel   = B_RT;
                e.ext_sel = EXT_NONE;
                e.wa      = WA_RD;
                case (fn)
                    6'h20: e.alu_op = ALU_ADD;
                    6'h21: e.alu_op = ALU_ADDU;
                    6'h22: e.alu_op = ALU_SUB;
                    6'h23: e.alu_op = ALU_SUBU;
                    6'h24: e.alu_op = ALU_AND;
                    6'h25: e.alu_op = ALU_OR;
                    6'h26: e.alu_op = ALU_XOR;
                    6'h27: e.alu_op = ALU_NOR;
                    6'h2a: e.alu_op = ALU_SLT;
                    6'h2b: e.alu_op = ALU_SLTU;
                    6'h00, 6'h04: e.alu_op = ALU_SLL;
                    6'h02, 6'h06: e.alu_op = ALU_SRL;
                    6'h03, 6'h07: e.alu_op = ALU_SRA;
                    6'h08, 6'h09: begin
                        e.group = G_JUMP;
                        e.links = fn[0];  // JALR
                        e.wa    = (ins[20:16] == 5'd0) ? WA_RA : WA_RD;
                    end
                    default: e.group = G_NOP;
                endcase
                case (fn)
                    6'h00, 6'h02, 6'h03: begin
                        e.a_sel   = A_SHAMT_IMM;
                        e.ext_sel = EXT_SHAMT;
                    end
                    6'h04, 6'h06, 6'h07: e.a_sel = A_SHAMT_RS;
                    default: ;
                endcase
                if (ins == 32'd0) begin
                    e.group = G_NOP;
                end
            end
            6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f: begin
                e.group   = G_ALU;
                e.b_sel   = B_IMM;
                e.wa      = WA_RT;
                e.ext_sel = (op <= 6'h0a) ? EXT_SIGN : EXT_ZERO; // ADDI, ADDIU, SLTI signed
                case (op[2:0])
                    3'd0:    e.alu_op = ALU_ADD;
                    3'd1:    e.alu_op = ALU_ADDU;
                    3'd2:    e.alu_op = ALU_SLT;
                    3'd3:    e.alu_op = ALU_SLTU;
                    3'd4:    e.alu_op = ALU_AND;
                    3'd5:    e.alu_op = ALU_OR;
                    3'd6:    e.alu_op = ALU_XOR;
                    default: e.alu_op = ALU_LUI;
                endcase
            end
            6'h01, 6'h04, 6'h05: begin
                e.group  = G_BRANCH;
                e.alu_op = ALU_SUB;
                e.b_sel  = (op == 6'h01) ? B_ZERO : B_RT;
                e.taken  = (op == 6'h04) ? zero : (op == 6'h05) ? !zero : !nega;
            end
            6'h20, 6'h21, 6'h23, 6'h24, 6'h25, 6'h28, 6'h29, 6'h2b: begin
                e.group = G_MEM;
                case (op)
                    6'h20:   e.ld = LD_BYTE;
                    6'h24:   e.ld = LD_BYTE_U;
                    6'h21:   e.ld = LD_HALF;
                    6'h25:   e.ld = LD_HALF_U;
                    6'h23:   e.ld = LD_WORD;
                    6'h28:   e.st = ST_BYTE;
                    6'h29:   e.st = ST_HALF;
                    default: e.st = ST_WORD;
                endcase
            end
            6'h02, 6'h03: begin
                e.group    = G_JUMP;
                e.absolute = 1'b1;
                e.links    = op[0]; // JAL
                e.wa       = WA_RA;
            end
            default: e.group = G_NOP;
        endcase
        case (e.group)
            G_ALU, G_MEM: e.cycles = 3'd4;
            G_BRANCH:     e.cycles = e.taken ? 3'd4 : 3'd3;
            G_JUMP:       e.cycles = e.links ? 3'd3 : 3'd2;
            default:      e.cycles = 3'd2;
        endcase
        return e;
    endfunction

    task automatic compare_value(input string test, input string sig,
                                 input logic [7:0] exp, input logic [7:0] act);
        check_count++;
        if (exp !== act) begin
            error_count++;
            $display("** Error %s %s: expected %0h, actual %0h (inst %h at %0t)",
                     test, sig, exp, act, inst, $time);
        end
    endtask

    //////////////////////////////
    // Compare once per cycle from index 0 at fetch
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            idx   = 0;
            first = 1'b1;
        end else begin
            case (idx)
                0: begin
                    cur   = reference(inst, alu_zero, alu_nega);
                    tname = first ? "reset_state" : "fetch";
                    first = 1'b0;
                    compare_value(tname, "pc_write", 1'b0, pc_write);
                    compare_value(tname, "reg_write", 1'b0, reg_write);
                    compare_value(tname, "finish", 1'b0, finish);
                    compare_value(tname, "store_size", ST_NONE, store_size);
                    compare_value(tname, "load_type", LD_NONE, load_type);
                    compare_value(tname, "wd_sel", WD_NONE, wd_sel);
                    compare_value(tname, "wa_sel", WA_NONE, wa_sel);
                    compare_value(tname, "jump_concat", 1'b0, jump_concat);
                    compare_value(tname, "im_read", 1'b1, im_read);
                    compare_value(tname, "pc_mux_ena", 1'b1, pc_mux_ena);
                    compare_value(tname, "alu_ena", 1'b1, alu_ena);
                    compare_value(tname, "zero_write", 1'b1, zero_write);
                end
                1: begin
                    compare_value("decode", "pc_write", 1'b1, pc_write);
                    if (cur.group == G_JUMP) begin
                        compare_value("jump", "pc_sel", cur.absolute ? PC_JUMP : PC_REG,
                                      pc_sel);
                        compare_value("jump", "jump_concat", cur.absolute, jump_concat);
                        compare_value("jump", "reg_write", cur.links, reg_write);
                        if (cur.links) begin
                            compare_value("jump", "wd_sel", WD_PC, wd_sel);
                            compare_value("jump", "wa_sel", cur.wa, wa_sel);
                        end
                    end
                end
                2: if (cur.group == G_ALU || cur.group == G_BRANCH) begin
                    tname = (cur.group == G_ALU) ? "alu" : "branch";
                    compare_value(tname, "alu_op", cur.alu_op, alu_op);
                    compare_value(tname, "a_sel", cur.a_sel, a_sel);
                    compare_value(tname, "b_sel", cur.b_sel, b_sel);
                    if (cur.group == G_ALU) begin
                        compare_value(tname, "ext_sel", cur.ext_sel, ext_sel);
                    end
                end
                3: begin
                    if (cur.group == G_ALU) begin
                        compare_value("alu", "reg_write", 1'b1, reg_write);
                        compare_value("alu", "wd_sel", WD_ALU, wd_sel);
                        compare_value("alu", "wa_sel", cur.wa, wa_sel);
                    end else if (cur.group == G_BRANCH) begin
                        compare_value("branch", "pc_write", 1'b1, pc_write);
                    end else if (cur.group == G_MEM) begin
                        compare_value("load_store", "load_type", cur.ld, load_type);
                        compare_value("load_store", "store_size", cur.st, store_size);
                        compare_value("load_store", "reg_write", cur.ld != LD_NONE, reg_write);
                        if (cur.ld != LD_NONE) begin
                            compare_value("load_store", "wd_sel", WD_MEM, wd_sel);
                            compare_value("load_store", "wa_sel", WA_RT, wa_sel);
                        end
                    end
                end
                default: ;
            endcase

            if (finish) begin
                compare_value("cycle_count", "cycles", cur.cycles, idx + 1);
                idx = 0;
            end else if (idx == 7) begin
                error_count++;
                $display("Error: no finish pulse within 8 cycles of fetch (inst %h at %0t)",
                         inst, $time);
                idx = 0;
            end else begin
                idx++;
            end
        end
    end

endmodule

//--- tb/tb_mcu_control.sv
`timescale 1ns/10ps

module tb_mcu_control import mcu_ctrl_pkg::*; ();

    localparam int N_INSNS    = 500;
    localparam int CLK_PERIOD = 100;

    // Supported primary opcodes and SPECIAL function codes
    localparam logic [125:0] OPCODES = {
        6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f, 6'h02, 6'h03, 6'h20,
        6'h21, 6'h23, 6'h24, 6'h25, 6'h28, 6'h29, 6'h2b, 6'h04, 6'h05, 6'h01
    };
    localparam logic [107:0] FUNCTS = {
        6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a,
        6'h2b, 6'h08, 6'h09, 6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07
    };

    logic        clk;
    logic        reset;
    logic [31:0] inst;
    logic        alu_zero;
    logic        alu_nega;
    logic        pc_mux_ena, pc_write, im_read, zero_write, alu_ena, reg_write;
    alu_op_t     alu_op;
    a_sel_t      a_sel;
    b_sel_t      b_sel;
    ext_sel_t    ext_sel;
    pc_sel_t     pc_sel;
    wd_sel_t     wd_sel;
    wa_sel_t     wa_sel;
    load_t       load_type;
    store_t      store_size;
    logic        jump_concat;
    logic        finish;
    int          seed;
    int          error_count;
    int          check_count;

    mcu_control i_dut (
        .clk(clk), .reset(reset), .inst(inst), .alu_zero(alu_zero), .alu_nega(alu_nega),
        .pc_mux_ena(pc_mux_ena), .pc_write(pc_write), .im_read(im_read),
        .zero_write(zero_write), .alu_ena(alu_ena), .reg_write(reg_write),
        .alu_op(alu_op), .a_sel(a_sel), .b_sel(b_sel), .ext_sel(ext_sel),
        .pc_sel(pc_sel), .wd_sel(wd_sel), .wa_sel(wa_sel), .load_type(load_type),
        .store_size(store_size), .jump_concat(jump_concat), .finish(finish)
    );

    mcu_checker i_checker (
        .clk(clk), .reset(reset), .inst(inst), .alu_zero(alu_zero), .alu_nega(alu_nega),
        .pc_mux_ena(pc_mux_ena), .pc_write(pc_write), .im_read(im_read),
        .zero_write(zero_write), .alu_ena(alu_ena), .reg_write(reg_write),
        .alu_op(alu_op), .a_sel(a_sel), .b_sel(b_sel), .ext_sel(ext_sel),
        .pc_sel(pc_sel), .wd_sel(wd_sel), .wa_sel(wa_sel), .load_type(load_type),
        .store_size(store_size), .jump_concat(jump_concat), .finish(finish),
        .error_count(error_count), .check_count(check_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic is_supported(input logic [5:0] op);
        logic hit;
        hit = (op == 6'h00);
        for (int k = 0; k < 21; k++) begin
            if (OPCODES[k * 6 +: 6] == op) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    //////////////////////////////
    // Stimulus
    function automatic logic [31:0] random_instruction();
        int          pick;
        logic [31:0] bits;
        logic [5:0]  op;
        logic [31:0] result;
        pick = {$random(seed)} % 100;
        bits = $random(seed);
        op   = OPCODES[({$random(seed)} % 21) * 6 +: 6];
        if (pick < 5) begin
            op = bits[31:26];
            while (is_supported(op)) begin
                op = op + 6'd1; // next free opcode
            end
            result = {op, bits[25:0]};
        end else if (pick < 10) begin
            result = 32'd0;
        end else if (pick < 45) begin
            result = {6'h00, bits[25:6], FUNCTS[({$random(seed)} % 18) * 6 +: 6]};
        end else begin
            result = {op, bits[25:0]};
        end
        return result;
    endfunction

    task automatic drive_flags();
        logic [31:0] r;
        r = $random(seed);
        alu_zero = r[0];
        alu_nega = r[1];
    endtask

    initial begin
        seed     = 32'h20d80f75;
        reset    = 1'b1;
        inst     = 32'd0;
        alu_zero = 1'b0;
        alu_nega = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        inst = random_instruction();
        drive_flags();
        reset = 1'b0;
        for (int n = 1; n <= N_INSNS; n++) begin
            do @(negedge clk); while (!finish);
            if (n < N_INSNS) begin
                inst = random_instruction(); // held through the next instruction
                @(negedge clk);
                drive_flags();               // Branch flags for this instruction
            end
        end
        @(negedge clk);
        $display("%0d instructions, %0d checks, %0d errors", N_INSNS, check_count, error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Worst case four cycles per instruction
    initial begin
        #((N_INSNS * 4 + 20) * CLK_PERIOD);
        $display("Timeout: the DUT stopped finishing instructions");
        $display("sim failed");
        $finish;
    end

endmodule
